//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    //--------------------------------------------------------------------------
    // widths
    //--------------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    //--------------------------------------------------------------------------
    // encodings
    //--------------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLL  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9
    } alu_op_t;

    // branch compare, same values as the branch funct3
    typedef enum logic [2:0] {
        CMP_BEQ  = 3'b000,
        CMP_BNE  = 3'b001,
        CMP_BLT  = 3'b100,
        CMP_BGE  = 3'b101,
        CMP_BLTU = 3'b110,
        CMP_BGEU = 3'b111
    } cmp_op_t;

    // load/store funct3, bits 1:0 give the access size
    typedef enum logic [2:0] {
        LSU_BYTE  = 3'b000,
        LSU_HALF  = 3'b001,
        LSU_WORD  = 3'b010,
        LSU_BYTEU = 3'b100,
        LSU_HALFU = 3'b101
    } lsu_size_t;

    // destination of a result
    typedef enum logic [1:0] {
        ZONE_NONE    = 2'd0,
        ZONE_REGFILE = 2'd1,
        ZONE_LOADQ   = 2'd2,
        ZONE_STOREQ  = 2'd3
    } zone_t;

    typedef enum logic [2:0] {
        EXCP_NONE  = 3'd0,
        EXCP_UERR  = 3'd1,
        EXCP_ECALL = 3'd2,
        EXCP_MAIF  = 3'd3,
        EXCP_MALA  = 3'd4,
        EXCP_MASA  = 3'd5
    } excp_cause_t;

endpackage

`default_nettype wire

//--- rtl/ex_bus_pkg.sv
`default_nettype none

package ex_bus_pkg;

    //--------------------------------------------------------------------------
    // decoder to execute stage
    //--------------------------------------------------------------------------
    typedef struct packed {
        logic                              valid;
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [1:0]                        ins_size;
        rv_isa_pkg::alu_op_t               alu_op;
        logic [rv_isa_pkg::XLEN-1:0]       operand_left;
        logic [rv_isa_pkg::XLEN-1:0]       operand_right;
        rv_isa_pkg::cmp_op_t               cmp_op;
        logic [rv_isa_pkg::XLEN-1:0]       cmp_left;
        logic [rv_isa_pkg::XLEN-1:0]       cmp_right;
        logic                              cond;
        logic                              jump;
        logic                              link;
        rv_isa_pkg::zone_t                 zone;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] regd_addr;
        logic [rv_isa_pkg::XLEN-1:0]       regs2_data;
        rv_isa_pkg::lsu_size_t             funct3;
        logic                              uerr;
        logic                              ecall;
    } ids_req_t;

    //--------------------------------------------------------------------------
    // internal stage register contents
    //--------------------------------------------------------------------------
    typedef struct packed {
        logic                              valid;
        logic [rv_isa_pkg::XLEN-1:0]       pc;
        logic [rv_isa_pkg::XLEN-1:0]       pc_inc;
        logic                              cond;
        logic                              jump;
        logic                              link;
        logic                              lq_wr;
        logic                              sq_wr;
        logic                              regd_wr;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] regd_addr;
        logic [rv_isa_pkg::XLEN-1:0]       regs2_data;
        rv_isa_pkg::lsu_size_t             funct3;
        logic                              uerr;
        logic                              ecall;
    } ctrl_t;

    typedef struct packed {
        logic [rv_isa_pkg::XLEN-1:0] data;
        logic                        cmp;
    } alu_res_t;

    //--------------------------------------------------------------------------
    // stage outputs
    //--------------------------------------------------------------------------
    typedef struct packed {
        logic                              wr;
        logic                              cncl_load;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] addr;
        logic [rv_isa_pkg::XLEN-1:0]       data;
    } wb_t;

    typedef struct packed {
        logic                              lq_wr;
        logic                              sq_wr;
        rv_isa_pkg::lsu_size_t             funct3;
        logic [rv_isa_pkg::REG_ADDR_W-1:0] regd_addr;
        logic [rv_isa_pkg::XLEN-1:0]       data;
        logic [rv_isa_pkg::XLEN-1:0]       addr;
    } lsq_req_t;

    typedef struct packed {
        logic                        valid;
        logic [rv_isa_pkg::XLEN-1:0] addr;
    } jump_t;

    typedef struct packed {
        logic                        valid;
        rv_isa_pkg::excp_cause_t     cause;
        logic [rv_isa_pkg::XLEN-1:0] pc;
    } excp_t;

endpackage

`default_nettype wire

//--- rtl/ex_ctrl_reg.sv
`timescale 1ns/1ns
`default_nettype none

module ex_ctrl_reg (
    input  logic                 clk_i,
    input  logic                 resetb_i,
    input  logic                 stage_en_i,
    input  ex_bus_pkg::ids_req_t ids_req_i,
    output ex_bus_pkg::ctrl_t    ctrl_o
);

    logic                        lq_wr_d;
    logic                        sq_wr_d;
    logic                        regd_wr_d;
    logic [rv_isa_pkg::XLEN-1:0] size_bytes;

    // zone to one-hot destination strobes
    always_comb begin
        lq_wr_d   = 1'b0;
        sq_wr_d   = 1'b0;
        regd_wr_d = 1'b0;
        case (ids_req_i.zone)
            rv_isa_pkg::ZONE_LOADQ   : lq_wr_d   = 1'b1;
            rv_isa_pkg::ZONE_STOREQ  : sq_wr_d   = 1'b1;
            rv_isa_pkg::ZONE_REGFILE : regd_wr_d = 1'b1;
            default : begin
            end
        endcase
    end

    // ins_size counts halfwords
    assign size_bytes = {{(rv_isa_pkg::XLEN-3){1'b0}}, ids_req_i.ins_size, 1'b0};

    always_ff @(posedge clk_i or negedge resetb_i) begin
        if (!resetb_i) begin
            ctrl_o.valid <= 1'b0;
        end else if (stage_en_i) begin
            ctrl_o.valid      <= ids_req_i.valid;
            ctrl_o.pc         <= ids_req_i.pc;
            ctrl_o.pc_inc     <= ids_req_i.pc + size_bytes;
            ctrl_o.cond       <= ids_req_i.cond;
            ctrl_o.jump       <= ids_req_i.jump;
            ctrl_o.link       <= ids_req_i.link;
            ctrl_o.lq_wr      <= lq_wr_d;
            ctrl_o.sq_wr      <= sq_wr_d;
            ctrl_o.regd_wr    <= regd_wr_d;
            ctrl_o.regd_addr  <= ids_req_i.regd_addr;
            ctrl_o.regs2_data <= ids_req_i.regs2_data;
            ctrl_o.funct3     <= ids_req_i.funct3;
            ctrl_o.uerr       <= ids_req_i.uerr;
            ctrl_o.ecall      <= ids_req_i.ecall;
        end
    end

    // a held instruction never targets two destinations
    a_zone_onehot : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        ctrl_o.valid |-> $onehot0({ctrl_o.lq_wr, ctrl_o.sq_wr, ctrl_o.regd_wr})
    );

endmodule

`default_nettype wire

//--- rtl/ex_alu.sv
`timescale 1ns/1ns
`default_nettype none

module ex_alu (
    input  logic                 clk_i,
    input  logic                 resetb_i,
    input  logic                 stage_en_i,
    input  ex_bus_pkg::ids_req_t ids_req_i,
    output ex_bus_pkg::alu_res_t alu_o
);

    logic [rv_isa_pkg::XLEN-1:0] op_left;
    logic [rv_isa_pkg::XLEN-1:0] op_right;
    logic [4:0]                  shamt;
    logic [rv_isa_pkg::XLEN-1:0] alu_data;
    logic [rv_isa_pkg::XLEN-1:0] cmp_left;
    logic [rv_isa_pkg::XLEN-1:0] cmp_right;
    logic                        cmp_res;

    assign op_left   = ids_req_i.operand_left;
    assign op_right  = ids_req_i.operand_right;
    assign shamt     = op_right[4:0];
    assign cmp_left  = ids_req_i.cmp_left;
    assign cmp_right = ids_req_i.cmp_right;

    //--------------------------------------------------------------------------
    // arithmetic and logic
    //--------------------------------------------------------------------------
    always_comb begin
        alu_data = '0;
        case (ids_req_i.alu_op)
            rv_isa_pkg::ALU_ADD  : alu_data = op_left + op_right;
            rv_isa_pkg::ALU_SUB  : alu_data = op_left - op_right;
            rv_isa_pkg::ALU_AND  : alu_data = op_left & op_right;
            rv_isa_pkg::ALU_OR   : alu_data = op_left | op_right;
            rv_isa_pkg::ALU_XOR  : alu_data = op_left ^ op_right;
            rv_isa_pkg::ALU_SLL  : alu_data = op_left << shamt;
            rv_isa_pkg::ALU_SRL  : alu_data = op_left >> shamt;
            rv_isa_pkg::ALU_SRA  : alu_data = $signed(op_left) >>> shamt;
            rv_isa_pkg::ALU_SLT  : alu_data[0] = $signed(op_left) < $signed(op_right);
            rv_isa_pkg::ALU_SLTU : alu_data[0] = op_left < op_right;
            default : alu_data = '0;
        endcase
    end

    //--------------------------------------------------------------------------
    // branch compare
    //--------------------------------------------------------------------------
    always_comb begin
        case (ids_req_i.cmp_op)
            rv_isa_pkg::CMP_BEQ  : cmp_res = cmp_left == cmp_right;
            rv_isa_pkg::CMP_BNE  : cmp_res = cmp_left != cmp_right;
            rv_isa_pkg::CMP_BLT  : cmp_res = $signed(cmp_left) < $signed(cmp_right);
            rv_isa_pkg::CMP_BGE  : cmp_res = $signed(cmp_left) >= $signed(cmp_right);
            rv_isa_pkg::CMP_BLTU : cmp_res = cmp_left < cmp_right;
            rv_isa_pkg::CMP_BGEU : cmp_res = cmp_left >= cmp_right;
            default : cmp_res = 1'b0;
        endcase
    end

    // result register, loads together with the control register
    always_ff @(posedge clk_i) begin
        if (stage_en_i) begin
            alu_o.data <= alu_data;
            alu_o.cmp  <= cmp_res;
        end
    end

    // decoder must only hand over known operations
    a_alu_op_defined : assert property (
        @(posedge clk_i) disable iff (!resetb_i)
        (stage_en_i && ids_req_i.valid) |-> (ids_req_i.alu_op inside {
            rv_isa_pkg::ALU_ADD, rv_isa_pkg::ALU_SUB, rv_isa_pkg::ALU_AND,
            rv_isa_pkg::ALU_OR, rv_isa_pkg::ALU_XOR, rv_isa_pkg::ALU_SLL,
            rv_isa_pkg::ALU_SRL, rv_isa_pkg::ALU_SRA, rv_isa_pkg::ALU_SLT,
            rv_isa_pkg::ALU_SLTU})
    );

endmodule

`default_nettype wire

//--- rtl/ex_commit.sv
`timescale 1ns/1ns
`default_nettype none

module ex_commit (
    input  ex_bus_pkg::ctrl_t    ctrl_i,
    input  ex_bus_pkg::alu_res_t alu_i,
    input  logic                 lsq_full_i,
    output logic                 stage_en_o,
    output ex_bus_pkg::wb_t      wb_o,
    output ex_bus_pkg::lsq_req_t lsq_o,
    output ex_bus_pkg::jump_t    jump_o,
    output ex_bus_pkg::excp_t    excp_o
);

    logic                    taken;
    logic                    misaligned;
    logic                    commit;
    logic                    stall;
    rv_isa_pkg::excp_cause_t cause;

    //--------------------------------------------------------------------------
    // exception detection
    //--------------------------------------------------------------------------
    assign taken = alu_i.cmp | ~ctrl_i.cond;

    // alu data is the effective address for loads and stores
    always_comb begin
        misaligned = 1'b0;
        if (ctrl_i.funct3 inside {rv_isa_pkg::LSU_HALF, rv_isa_pkg::LSU_HALFU}) begin
            misaligned = alu_i.data[0];
        end else if (ctrl_i.funct3 == rv_isa_pkg::LSU_WORD) begin
            misaligned = |alu_i.data[1:0];
        end
    end

    // fixed priority, first match wins
    always_comb begin
        if (ctrl_i.uerr) begin
            cause = rv_isa_pkg::EXCP_UERR;
        end else if (ctrl_i.ecall) begin
            cause = rv_isa_pkg::EXCP_ECALL;
        end else if (ctrl_i.jump && taken && |alu_i.data[1:0]) begin
            cause = rv_isa_pkg::EXCP_MAIF;
        end else if (ctrl_i.lq_wr && misaligned) begin
            cause = rv_isa_pkg::EXCP_MALA;
        end else if (ctrl_i.sq_wr && misaligned) begin
            cause = rv_isa_pkg::EXCP_MASA;
        end else begin
            cause = rv_isa_pkg::EXCP_NONE;
        end
    end

    //--------------------------------------------------------------------------
    // commit and stall
    //--------------------------------------------------------------------------
    assign commit = ctrl_i.valid & taken & (cause == rv_isa_pkg::EXCP_NONE);

    // queue write with no room, hold everything
    assign stall      = commit & lsq_full_i & (ctrl_i.lq_wr | ctrl_i.sq_wr);
    assign stage_en_o = ~stall;

    //--------------------------------------------------------------------------
    // outputs
    //--------------------------------------------------------------------------
    assign wb_o.wr        = stage_en_o & commit & ctrl_i.regd_wr;
    assign wb_o.cncl_load = stage_en_o & ctrl_i.valid & ~commit & ctrl_i.lq_wr;
    assign wb_o.addr      = ctrl_i.regd_addr;
    assign wb_o.data      = ctrl_i.link ? ctrl_i.pc_inc : alu_i.data;

    assign lsq_o.lq_wr     = stage_en_o & commit & ctrl_i.lq_wr;
    assign lsq_o.sq_wr     = stage_en_o & commit & ctrl_i.sq_wr;
    assign lsq_o.funct3    = ctrl_i.funct3;
    assign lsq_o.regd_addr = ctrl_i.regd_addr;
    assign lsq_o.data      = ctrl_i.regs2_data;
    assign lsq_o.addr      = alu_i.data;

    assign jump_o.valid = stage_en_o & commit & ctrl_i.jump;
    assign jump_o.addr  = alu_i.data;

    assign excp_o.valid = stage_en_o & ctrl_i.valid & (cause != rv_isa_pkg::EXCP_NONE);
    assign excp_o.cause = cause;
    assign excp_o.pc    = ctrl_i.pc;

    // output consistency
    always_comb begin
        a_jump_excp : assert (!(jump_o.valid && excp_o.valid));
        a_lq_sq : assert (!(lsq_o.lq_wr && lsq_o.sq_wr));
        a_no_strobe_stalled : assert (stage_en_o || !(wb_o.wr || wb_o.cncl_load ||
            lsq_o.lq_wr || lsq_o.sq_wr || jump_o.valid || excp_o.valid));
    end

endmodule

`default_nettype wire

//--- rtl/ex_stage.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
    input  logic                 clk_i,
    input  logic                 resetb_i,
    input  ex_bus_pkg::ids_req_t ids_req_i,
    output logic                 ids_stall_o,
    input  logic                 lsq_full_i,
    output ex_bus_pkg::wb_t      wb_o,
    output ex_bus_pkg::lsq_req_t lsq_o,
    output ex_bus_pkg::jump_t    jump_o,
    output ex_bus_pkg::excp_t    excp_o
);

    ex_bus_pkg::ctrl_t    ctrl;
    ex_bus_pkg::alu_res_t alu_res;
    logic                 stage_en;

    assign ids_stall_o = ~stage_en;

    ex_ctrl_reg u_ex_ctrl_reg (
        .clk_i      (clk_i),
        .resetb_i   (resetb_i),
        .stage_en_i (stage_en),
        .ids_req_i  (ids_req_i),
        .ctrl_o     (ctrl)
    );

    ex_alu u_ex_alu (
        .clk_i      (clk_i),
        .resetb_i   (resetb_i),
        .stage_en_i (stage_en),
        .ids_req_i  (ids_req_i),
        .alu_o      (alu_res)
    );

    ex_commit u_ex_commit (
        .ctrl_i     (ctrl),
        .alu_i      (alu_res),
        .lsq_full_i (lsq_full_i),
        .stage_en_o (stage_en),
        .wb_o       (wb_o),
        .lsq_o      (lsq_o),
        .jump_o     (jump_o),
        .excp_o     (excp_o)
    );

endmodule

`default_nettype wire

//--- tb/ex_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ex_stage_tb;

    typedef struct {
        ex_bus_pkg::ids_req_t req;
        int                   full;
        ex_bus_pkg::wb_t      wb;
        ex_bus_pkg::lsq_req_t lsq;
        ex_bus_pkg::jump_t    jmp;
        ex_bus_pkg::excp_t    excp;
    } test_t;

    logic                 clk_i = 1'b0;
    logic                 resetb_i;
    ex_bus_pkg::ids_req_t ids_req;
    logic                 lsq_full;
    logic                 ids_stall;
    ex_bus_pkg::wb_t      wb;
    ex_bus_pkg::lsq_req_t lsq;
    ex_bus_pkg::jump_t    jmp;
    ex_bus_pkg::excp_t    excp;

    test_t       tests[$];
    logic [31:0] lfsr = 32'h7e58;
    int          cur;

    always #4 clk_i = ~clk_i;

    ex_stage u_ex_stage (
        .clk_i       (clk_i),
        .resetb_i    (resetb_i),
        .ids_req_i   (ids_req),
        .ids_stall_o (ids_stall),
        .lsq_full_i  (lsq_full),
        .wb_o        (wb),
        .lsq_o       (lsq),
        .jump_o      (jmp),
        .excp_o      (excp)
    );

    // ------------------------------------------------------------------------
    // random timing jitter
    // ------------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val  = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: test %0d %s", $time, cur, msg);
        $display("Test failures found");
        $fatal(1);
    endtask

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_stall(input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("ids_stall got %0b exp %0b", got, exp));
    endtask

    task automatic check_wb(input ex_bus_pkg::wb_t got, input ex_bus_pkg::wb_t exp);
        if (got.wr !== exp.wr || got.cncl_load !== exp.cncl_load)
            report_mismatch($sformatf("wb.wr/cncl_load got %0b%0b exp %0b%0b",
                got.wr, got.cncl_load, exp.wr, exp.cncl_load));
        if (exp.wr && (got.addr !== exp.addr || got.data !== exp.data))
            report_mismatch($sformatf("wb.addr/data got %0d %h exp %0d %h",
                got.addr, got.data, exp.addr, exp.data));
    endtask

    task automatic check_lsq(input ex_bus_pkg::lsq_req_t got, input ex_bus_pkg::lsq_req_t exp);
        if (got.lq_wr !== exp.lq_wr || got.sq_wr !== exp.sq_wr)
            report_mismatch($sformatf("lsq.lq_wr/sq_wr got %0b%0b exp %0b%0b",
                got.lq_wr, got.sq_wr, exp.lq_wr, exp.sq_wr));
        if ((exp.lq_wr || exp.sq_wr) && got !== exp)
            report_mismatch($sformatf("lsq payload got %h exp %h", got, exp));
    endtask

    task automatic check_jump(input ex_bus_pkg::jump_t got, input ex_bus_pkg::jump_t exp);
        if (got.valid !== exp.valid)
            report_mismatch($sformatf("jump.valid got %0b exp %0b", got.valid, exp.valid));
        if (exp.valid && got.addr !== exp.addr)
            report_mismatch($sformatf("jump.addr got %h exp %h", got.addr, exp.addr));
    endtask

    task automatic check_excp(input ex_bus_pkg::excp_t got, input ex_bus_pkg::excp_t exp);
        if (got.valid !== exp.valid)
            report_mismatch($sformatf("excp.valid got %0b exp %0b", got.valid, exp.valid));
        if (exp.valid && (got.cause !== exp.cause || got.pc !== exp.pc))
            report_mismatch($sformatf("excp.cause/pc got %0d %h exp %0d %h",
                got.cause, got.pc, exp.cause, exp.pc));
    endtask

    // nothing retires in a bubble cycle
    task automatic expect_idle();
        check_stall(ids_stall, 1'b0);
        check_wb(wb, '0);
        check_lsq(lsq, '0);
        check_jump(jmp, '0);
        check_excp(excp, '0);
    endtask

    // ------------------------------------------------------------------------
    // test file
    // ------------------------------------------------------------------------
    task automatic load_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] v[28];
        test_t       t;

        fd = $fopen("tb/ex_stage_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/ex_stage_tests.txt");
            $display("Test failures found");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                    v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19],
                    v[20], v[21], v[22], v[23], v[24], v[25], v[26], v[27]);
                t.req               = '0;
                t.req.valid         = 1'b1;
                t.req.pc            = v[0];
                t.req.ins_size      = v[1][1:0];
                t.req.alu_op        = rv_isa_pkg::alu_op_t'(v[2][3:0]);
                t.req.operand_left  = v[3];
                t.req.operand_right = v[4];
                t.req.cmp_op        = rv_isa_pkg::cmp_op_t'(v[5][2:0]);
                t.req.cmp_left      = v[6];
                t.req.cmp_right     = v[7];
                t.req.cond          = v[8][0];
                t.req.jump          = v[9][0];
                t.req.link          = v[10][0];
                t.req.zone          = rv_isa_pkg::zone_t'(v[11][1:0]);
                t.req.regd_addr     = v[12][4:0];
                t.req.regs2_data    = v[13];
                t.req.funct3        = rv_isa_pkg::lsu_size_t'(v[14][2:0]);
                t.req.uerr          = v[15][0];
                t.req.ecall         = v[16][0];
                t.full              = int'(v[17]);
                t.wb                = '{v[18][0], v[19][0], v[12][4:0], v[20]};
                t.lsq               = '{v[21][0], v[22][0], t.req.funct3, v[12][4:0],
                                        v[13], v[23]};
                t.jmp               = '{v[24][0], v[25]};
                t.excp              = '{v[26][0], rv_isa_pkg::excp_cause_t'(v[27][2:0]), v[0]};
                tests.push_back(t);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        int   gap;
        int   extra;
        int   full;
        logic presented;

        resetb_i  = 1'b0;
        ids_req   = '0;
        lsq_full  = 1'b0;
        presented = 1'b0;
        load_tests();
        fork
            begin
                #(tests.size() * 40 * 8);
                $display("timeout: the DUT did not retire all instructions in time");
                $display("Test failures found");
                $fatal(1);
            end
        join_none
        repeat (4) @(posedge clk_i);
        #1 resetb_i = 1'b1;

        take_bits(2, gap);
        for (cur = 0; cur < tests.size(); cur++) begin
            // idle gap before an instruction that is not already waiting
            if (!presented) begin
                repeat (gap) begin
                    @(negedge clk_i);
                    expect_idle();
                    @(posedge clk_i);
                    #1;
                end
                ids_req = tests[cur].req;
                // loaded on this edge
                @(posedge clk_i);
                #1;
            end
            // with no gap the next instruction waits on the bus through any stall
            take_bits(2, gap);
            presented = (gap == 0) && (cur + 1 < tests.size());
            if (presented)
                ids_req = tests[cur + 1].req;
            else
                ids_req = '0;
            full = tests[cur].full;
            if (full > 0) begin
                take_bits(2, extra);
                full += extra;
            end
            lsq_full = (full > 0);
            repeat (full) begin
                @(negedge clk_i);
                check_stall(ids_stall, tests[cur].lsq.lq_wr | tests[cur].lsq.sq_wr);
                check_wb(wb, '0);
                check_lsq(lsq, '0);
                check_jump(jmp, '0);
                check_excp(excp, '0);
                @(posedge clk_i);
                #1;
            end
            lsq_full = 1'b0;
            @(negedge clk_i);
            check_stall(ids_stall, 1'b0);
            check_wb(wb, tests[cur].wb);
            check_lsq(lsq, tests[cur].lsq);
            check_jump(jmp, tests[cur].jmp);
            check_excp(excp, tests[cur].excp);
            // retire edge, a waiting instruction loads here
            @(posedge clk_i);
            #1;
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/ex_stage_tests.txt
# pc sz aluop opl opr cmpop cmpl cmpr cond jump link zone rd rs2 f3 uerr ecall full
# then expected: wb_wr cncl wb_data lq_wr sq_wr lsq_addr jump_v jump_addr excp_v cause
100 2 0 5 7 0 0 0 0 0 0 1 03 0 0 0 0 0 1 0 c 0 0 0 0 0 0 0
104 2 1 5 7 0 0 0 0 0 0 1 04 0 0 0 0 0 1 0 fffffffe 0 0 0 0 0 0 0
108 2 2 f0f0 ff00 0 0 0 0 0 0 1 05 0 0 0 0 0 1 0 f000 0 0 0 0 0 0 0
10c 2 3 f0f0 0f0f 0 0 0 0 0 0 1 06 0 0 0 0 0 1 0 ffff 0 0 0 0 0 0 0
110 2 4 ff 0f 0 0 0 0 0 0 1 07 0 0 0 0 0 1 0 f0 0 0 0 0 0 0 0
114 2 5 1 24 0 0 0 0 0 0 1 08 0 0 0 0 0 1 0 10 0 0 0 0 0 0 0
118 2 6 80000000 1f 0 0 0 0 0 0 1 09 0 0 0 0 0 1 0 1 0 0 0 0 0 0 0
11c 2 7 80000000 4 0 0 0 0 0 0 1 0a 0 0 0 0 0 1 0 f8000000 0 0 0 0 0 0 0
120 2 8 ffffffff 1 0 0 0 0 0 0 1 0b 0 0 0 0 0 1 0 1 0 0 0 0 0 0 0
124 2 9 ffffffff 1 0 0 0 0 0 0 1 0c 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0
200 2 0 200 10 0 0 0 0 1 1 1 01 0 0 0 0 0 1 0 204 0 0 0 1 210 0 0
300 2 0 300 20 0 5 5 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 1 320 0 0
304 2 0 304 20 0 5 6 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
308 2 0 308 20 1 5 5 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
30c 2 0 30c 20 4 1 ffffffff 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
310 2 0 310 20 5 ffffffff 1 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
314 2 0 314 20 6 ffffffff 1 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
318 2 0 318 20 7 1 ffffffff 1 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
400 2 0 1000 8 0 0 0 0 0 0 2 05 0 2 0 0 0 0 0 0 1 0 1008 0 0 0 0
404 2 0 2000 4 0 0 0 0 0 0 3 00 deadbeef 2 0 0 0 0 0 0 0 1 2004 0 0 0 0
408 2 0 1000 0 0 1 2 1 0 0 2 06 0 2 0 0 0 0 1 0 0 0 0 0 0 0 0
500 2 0 400 2 0 0 0 0 1 0 0 00 0 0 0 0 0 0 0 0 0 0 0 0 0 1 3
504 2 0 1000 1 0 0 0 0 0 0 2 05 0 1 0 0 0 0 1 0 0 0 0 0 0 1 4
508 2 0 2000 2 0 0 0 0 0 0 3 00 0 2 0 0 0 0 0 0 0 0 0 0 0 1 5
50c 2 0 0 0 0 0 0 0 0 0 1 02 0 0 1 1 0 0 0 0 0 0 0 0 0 1 1
510 2 0 0 0 0 0 0 0 0 0 1 02 0 0 0 1 0 0 0 0 0 0 0 0 0 1 2
600 2 0 3000 0 0 0 0 0 0 0 3 00 12345678 2 0 0 3 0 0 0 0 1 3000 0 0 0 0
604 2 0 1 1 0 0 0 0 0 0 1 01 0 0 0 0 0 1 0 2 0 0 0 0 0 0 0

//--- build.f
rtl/rv_isa_pkg.sv
rtl/ex_bus_pkg.sv
rtl/ex_ctrl_reg.sv
rtl/ex_alu.sv
rtl/ex_commit.sv
rtl/ex_stage.sv
tb/ex_stage_tb.sv

//--- Makefile
TOP       ?= ex_stage_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	$(VERILATOR) --binary --assert -f build.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
